// ==== Makefile ====
TOP := marlann_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== common/marlann_pipe_if.sv ====
`timescale 1ns/1ps

// One command travelling from one pipeline stage to the next.
interface marlann_pipe_if;
	import marlann_pkg::*;

	logic                    en;     // One cycle strobe per item.
	logic [opcode_width-1:0] opcode;
	logic [maddr_width-1:0]  maddr;
	logic [caddr_width-1:0]  caddr;

	modport up (
		output en,
		output opcode,
		output maddr,
		output caddr
	);

	modport down (
		input en,
		input opcode,
		input maddr,
		input caddr
	);

endinterface

// ==== common/marlann_pkg.sv ====
package marlann_pkg;

	// ------------------------------------------------------------
	// Field and datapath widths
	// ------------------------------------------------------------

	localparam int maddr_width    = 17; // Memory byte address field of a command.
	localparam int caddr_width    = 9;  // Coefficient address field, also the shift amount.
	localparam int opcode_width   = 6;
	localparam int mem_addr_width = 16; // Memory word address.
	localparam int mem_data_width = 64;
	localparam int mem_lanes      = 8;  // Byte lanes in one memory word.
	localparam int acc_width      = 32;
	localparam int sum_width      = 20; // Holds the sum of eight signed 16 bit products.

	// ------------------------------------------------------------
	// Opcodes
	// ------------------------------------------------------------

	localparam logic [opcode_width-1:0] op_load_coeff0 = 6'd5;
	localparam logic [opcode_width-1:0] op_load_coeff1 = 6'd6;
	localparam logic [opcode_width-1:0] op_set_vbp     = 6'd8;
	localparam logic [opcode_width-1:0] op_add_vbp     = 6'd9;
	localparam logic [opcode_width-1:0] op_set_sbp     = 6'd12;
	localparam logic [opcode_width-1:0] op_add_sbp     = 6'd13;
	localparam logic [opcode_width-1:0] op_set_cbp     = 6'd14;
	localparam logic [opcode_width-1:0] op_add_cbp     = 6'd15;
	localparam logic [opcode_width-1:0] op_store       = 6'd16;
	localparam logic [opcode_width-1:0] op_store0      = 6'd17;
	localparam logic [opcode_width-1:0] op_store1      = 6'd18;
	localparam logic [opcode_width-1:0] op_relu        = 6'd20;
	localparam logic [opcode_width-1:0] op_relu0       = 6'd21;
	localparam logic [opcode_width-1:0] op_relu1       = 6'd22;
	localparam logic [opcode_width-1:0] op_macc        = 6'd40;
	localparam logic [opcode_width-1:0] op_maccz       = 6'd42;

	// ------------------------------------------------------------
	// Timing
	// ------------------------------------------------------------

	localparam int mem_read_latency = 2; // Request in cycle c, data in cycle c+2.
	localparam int pipe_depth       = 6; // Acceptance to the memory write.

endpackage

// ==== compute/marlann_accum.sv ====
`timescale 1ns/1ps

module marlann_accum (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [marlann_pkg::sum_width-1:0] sum0,
	input  logic [marlann_pkg::sum_width-1:0] sum1,
	marlann_pipe_if.down                      prev_item,
	output logic [7:0]                        sat0,
	output logic [7:0]                        sat1,
	marlann_pipe_if.up                        next_item
);
	import marlann_pkg::*;

	logic signed [acc_width-1:0] acc0;
	logic signed [acc_width-1:0] acc1;
	logic                        do_macc;
	logic                        do_maccz;

	// Arithmetic shift right, then clamp to a signed byte.
	function automatic logic [7:0] saturate(
		input logic signed [acc_width-1:0] value,
		input logic [caddr_width-1:0]      shift
	);
		logic signed [acc_width-1:0] shifted;
		shifted = value >>> shift;
		if (shifted > 127) begin
			return 8'h7f;
		end
		if (shifted < -128) begin
			return 8'h80;
		end
		return shifted[7:0];
	endfunction

	assign do_macc  = prev_item.en && prev_item.opcode == op_macc;
	assign do_maccz = prev_item.en && prev_item.opcode == op_maccz;

	always_ff @(posedge clock) begin
		if (do_macc) begin
			acc0 <= acc0 + $signed(sum0);
			acc1 <= acc1 + $signed(sum1);
		end else if (do_maccz) begin
			acc0 <= $signed(sum0); // Start a new dot product.
			acc1 <= $signed(sum1);
		end

		sat0 <= saturate(acc0, prev_item.caddr); // Sees every MACC issued before this item.
		sat1 <= saturate(acc1, prev_item.caddr);

		next_item.en     <= prev_item.en;
		next_item.opcode <= prev_item.opcode;
		next_item.maddr  <= prev_item.maddr;
		next_item.caddr  <= prev_item.caddr;

		if (reset) begin
			acc0         <= '0;
			acc1         <= '0;
			next_item.en <= 1'b0;
		end
	end

endmodule

// ==== compute/marlann_coeff.sv ====
`timescale 1ns/1ps

module marlann_coeff #(
	parameter int coeff_depth = 512
) (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic [marlann_pkg::mem_data_width-1:0]   mem_rdata,
	marlann_pipe_if.down                             prev_item,
	output logic [2*marlann_pkg::mem_data_width-1:0] coeff,
	output logic [marlann_pkg::mem_data_width-1:0]   rdata,
	marlann_pipe_if.up                               next_item
);
	import marlann_pkg::*;

	localparam int last_stage = mem_read_latency - 1; // Item meets its read data here.
	localparam int read_stage = mem_read_latency - 2; // Entry read one cycle earlier.

	logic [2*mem_data_width-1:0] coeff_mem [0:coeff_depth-1];
	logic [caddr_width-1:0]      cbp;
	logic [mem_read_latency-1:0] en_q;
	logic [opcode_width-1:0]     opcode_q [mem_read_latency];
	logic [maddr_width-1:0]      maddr_q  [mem_read_latency];
	logic [caddr_width-1:0]      caddr_q  [mem_read_latency];
	logic [caddr_width-1:0]      rd_index;

	assign rd_index = caddr_q[read_stage] + cbp;
	assign rdata    = mem_rdata; // Already aligned with the item in the last stage.

	assign next_item.en     = en_q[last_stage];
	assign next_item.opcode = opcode_q[last_stage];
	assign next_item.maddr  = maddr_q[last_stage];
	assign next_item.caddr  = caddr_q[last_stage];

	always_ff @(posedge clock) begin
		en_q        <= {en_q[mem_read_latency-2:0], prev_item.en};
		opcode_q[0] <= prev_item.opcode;
		maddr_q[0]  <= prev_item.maddr;
		caddr_q[0]  <= prev_item.caddr;
		for (int i = 1; i < mem_read_latency; i++) begin
			opcode_q[i] <= opcode_q[i-1];
			maddr_q[i]  <= maddr_q[i-1];
			caddr_q[i]  <= caddr_q[i-1];
		end

		coeff <= coeff_mem[rd_index];

		if (en_q[read_stage] &&
		    (opcode_q[read_stage] == op_set_cbp || opcode_q[read_stage] == op_add_cbp)) begin
			cbp <= caddr_q[read_stage] + (opcode_q[read_stage][0] ? cbp : '0);
		end

		if (reset) begin
			en_q <= '0;
			cbp  <= '0;
		end
	end

	// Loads write at caddr without the base pointer.
	always_ff @(posedge clock) begin
		if (en_q[last_stage] && opcode_q[last_stage] == op_load_coeff0) begin
			coeff_mem[caddr_q[last_stage]][mem_data_width-1:0] <= mem_rdata;
		end
		if (en_q[last_stage] && opcode_q[last_stage] == op_load_coeff1) begin
			coeff_mem[caddr_q[last_stage]][2*mem_data_width-1:mem_data_width] <= mem_rdata;
		end
	end

endmodule

// ==== compute/marlann_issue.sv ====
`timescale 1ns/1ps

module marlann_issue (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   cmd_valid,
	input  logic [31:0]                            cmd_insn,
	output logic                                   cmd_ready,
	output logic                                   busy,
	output logic                                   mem_ren,
	output logic [marlann_pkg::mem_addr_width-1:0] rd_addr,
	marlann_pipe_if.up                             next_item
);
	import marlann_pkg::*;

	logic [maddr_width-1:0]  insn_maddr;
	logic [caddr_width-1:0]  insn_caddr;
	logic [opcode_width-1:0] insn_opcode;
	logic                    reads_mem;  // Command needs the memory read port.
	logic                    holds_lock; // Command blocks later memory reads.
	logic                    is_macc;
	logic                    accept;
	logic [pipe_depth-1:0]   in_flight;  // Bit k marks an item in cycle ck.
	logic [pipe_depth-1:0]   lock;
	logic [maddr_width-1:0]  vbp;
	logic [maddr_width-1:0]  read_base;

	assign insn_maddr  = cmd_insn[31 -: maddr_width];
	assign insn_caddr  = cmd_insn[opcode_width +: caddr_width];
	assign insn_opcode = cmd_insn[opcode_width-1:0];

	always_comb begin
		reads_mem  = 1'b0;
		holds_lock = 1'b0;
		is_macc    = 1'b0;
		case (insn_opcode)
			op_load_coeff0, op_load_coeff1: begin
				reads_mem  = 1'b1;
				holds_lock = 1'b1; // The coefficient write lands after later reads of it.
			end
			op_macc, op_maccz: begin
				reads_mem = 1'b1;
				is_macc   = 1'b1;
			end
			op_store, op_store0, op_store1, op_relu, op_relu0, op_relu1: begin
				holds_lock = 1'b1;
			end
			default: begin
				reads_mem = 1'b0;
			end
		endcase
	end

	// A reader waits until every earlier writer has left the pipeline.
	assign cmd_ready = !(reads_mem && |lock);
	assign accept    = cmd_valid && cmd_ready;

	assign read_base = insn_maddr + (is_macc ? vbp : '0);

	// ------------------------------------------------------------
	// Tracking and read request
	// ------------------------------------------------------------

	always_ff @(posedge clock) begin
		in_flight <= {in_flight[pipe_depth-2:0], accept};
		lock      <= {lock[pipe_depth-2:0], accept && holds_lock};
		busy      <= accept || |in_flight; // Registered, so it also covers the write cycle.
		mem_ren   <= accept && reads_mem;
		rd_addr   <= read_base[maddr_width-1:1];

		next_item.en     <= accept;
		next_item.opcode <= insn_opcode;
		next_item.maddr  <= insn_maddr;
		next_item.caddr  <= insn_caddr;

		if (accept && (insn_opcode == op_set_vbp || insn_opcode == op_add_vbp)) begin
			vbp <= insn_maddr + (insn_opcode[0] ? vbp : '0); // Bit 0 selects add.
		end

		if (reset) begin
			in_flight    <= '0;
			lock         <= '0;
			busy         <= 1'b0;
			mem_ren      <= 1'b0;
			next_item.en <= 1'b0;
			vbp          <= '0;
		end
	end

endmodule

// ==== compute/marlann_mac.sv ====
`timescale 1ns/1ps

module marlann_mac (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic [2*marlann_pkg::mem_data_width-1:0] coeff,
	input  logic [marlann_pkg::mem_data_width-1:0]   rdata,
	marlann_pipe_if.down                             prev_item,
	output logic [marlann_pkg::sum_width-1:0]        sum0,
	output logic [marlann_pkg::sum_width-1:0]        sum1,
	marlann_pipe_if.up                               next_item
);
	import marlann_pkg::*;

	localparam int prod_width = 16; // Signed 8x8 product.

	logic [mem_lanes-1:0][prod_width-1:0] prod0; // Data times low coefficient half.
	logic [mem_lanes-1:0][prod_width-1:0] prod1; // Data times high coefficient half.
	logic                    s3_en;
	logic [opcode_width-1:0] s3_opcode;
	logic [maddr_width-1:0]  s3_maddr;
	logic [caddr_width-1:0]  s3_caddr;

	function automatic logic [sum_width-1:0] tree_sum(
		input logic [mem_lanes-1:0][prod_width-1:0] terms
	);
		logic signed [sum_width-1:0] total;
		total = '0;
		for (int i = 0; i < mem_lanes; i++) begin
			total = total + $signed(terms[i]); // Sign extended to the sum width.
		end
		return total;
	endfunction

	always_ff @(posedge clock) begin
		for (int i = 0; i < mem_lanes; i++) begin
			prod0[i] <= $signed(rdata[8*i +: 8]) * $signed(coeff[8*i +: 8]);
			prod1[i] <= $signed(rdata[8*i +: 8]) * $signed(coeff[mem_data_width + 8*i +: 8]);
		end

		sum0 <= tree_sum(prod0);
		sum1 <= tree_sum(prod1);

		s3_en     <= prev_item.en;
		s3_opcode <= prev_item.opcode;
		s3_maddr  <= prev_item.maddr;
		s3_caddr  <= prev_item.caddr;

		next_item.en     <= s3_en;
		next_item.opcode <= s3_opcode;
		next_item.maddr  <= s3_maddr;
		next_item.caddr  <= s3_caddr;

		if (reset) begin
			s3_en        <= 1'b0;
			next_item.en <= 1'b0;
		end
	end

endmodule

// ==== compute/marlann_writeback.sv ====
`timescale 1ns/1ps

module marlann_writeback (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic [7:0]                             sat0,
	input  logic [7:0]                             sat1,
	marlann_pipe_if.down                           prev_item,
	output logic [marlann_pkg::mem_lanes-1:0]      mem_wen,
	output logic [marlann_pkg::mem_addr_width-1:0] wr_addr,
	output logic [marlann_pkg::mem_data_width-1:0] mem_wdata
);
	import marlann_pkg::*;

	logic [maddr_width-1:0] sbp;
	logic [maddr_width-1:0] byte_addr;
	logic [1:0]             lane_en; // Bit 0 for acc0, bit 1 for acc1.
	logic                   relu;
	logic [7:0]             byte0;
	logic [7:0]             byte1;

	always_comb begin
		lane_en = 2'b00;
		relu    = 1'b0;
		case (prev_item.opcode)
			op_store:  lane_en = 2'b11;
			op_store0: lane_en = 2'b01;
			op_store1: lane_en = 2'b10;
			op_relu: begin
				lane_en = 2'b11;
				relu    = 1'b1;
			end
			op_relu0: begin
				lane_en = 2'b01;
				relu    = 1'b1;
			end
			op_relu1: begin
				lane_en = 2'b10;
				relu    = 1'b1;
			end
			default: lane_en = 2'b00;
		endcase
		if (!prev_item.en) begin
			lane_en = 2'b00;
		end
	end

	assign byte0     = (relu && sat0[7]) ? 8'h00 : sat0;
	assign byte1     = (relu && sat1[7]) ? 8'h00 : sat1;
	assign byte_addr = prev_item.maddr + sbp;

	// ------------------------------------------------------------
	// Memory write that moves up one byte lane for an odd address
	// ------------------------------------------------------------

	always_ff @(posedge clock) begin
		mem_wen   <= {{(mem_lanes-2){1'b0}}, lane_en} << byte_addr[0];
		mem_wdata <= {{(mem_data_width-16){1'b0}}, byte1, byte0} << {byte_addr[0], 3'b000};
		wr_addr   <= byte_addr[maddr_width-1:1];

		if (prev_item.en && (prev_item.opcode == op_set_sbp || prev_item.opcode == op_add_sbp)) begin
			sbp <= prev_item.maddr + (prev_item.opcode[0] ? sbp : '0);
		end

		if (reset) begin
			mem_wen <= '0;
			sbp     <= '0;
		end
	end

endmodule

// ==== sim.f ====
+incdir+tests
common/marlann_pkg.sv
common/marlann_pipe_if.sv
compute/marlann_issue.sv
compute/marlann_coeff.sv
compute/marlann_mac.sv
compute/marlann_accum.sv
compute/marlann_writeback.sv
verilog/marlann_top.sv
tests/marlann_tb.sv

// ==== tests/marlann_tb_ref.svh ====
`ifndef marlann_tb_ref_svh
`define marlann_tb_ref_svh

	// ------------------------------------------------------------
	// Reference model state
	// ------------------------------------------------------------

	logic [63:0]  exp_mem [0:65535];  // Expected memory contents.
	logic [127:0] ref_coeff [0:511];
	logic [16:0]  ref_vbp;
	logic [16:0]  ref_sbp;
	logic [8:0]   ref_cbp;
	int           ref_acc0;
	int           ref_acc1;
	logic [15:0]  touched [$];        // Word addresses written by stores since the last compare.
	logic [31:0]  lcg_state;
	int           check_count;
	int           error_count;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Uses the upper bits only because the low bits of an LCG repeat quickly.
	function automatic int rand_below(int limit);
		return int'(lcg_next() >> 16) % limit;
	endfunction

	function automatic int dot8(logic [63:0] data, logic [63:0] weights);
		int  total;
		byte d;
		byte w;
		total = 0;
		for (int i = 0; i < 8; i++) begin
			d = data[8*i +: 8];
			w = weights[8*i +: 8];
			total += d * w;
		end
		return total;
	endfunction

	// Arithmetic shift right by the store's caddr, then clamp to -128..127.
	function automatic logic [7:0] to_byte(int acc, logic [8:0] shift);
		longint scaled;
		scaled = longint'(acc) >>> ((shift > 40) ? 40 : shift);
		if (scaled > 127) begin
			return 8'h7f;
		end else if (scaled < -128) begin
			return 8'h80;
		end
		return scaled[7:0];
	endfunction

	// Updates the model with one command, in the order the commands are sent.
	function automatic void apply_command(logic [31:0] insn);
		logic [16:0] maddr;
		logic [8:0]  caddr;
		logic [5:0]  op;
		logic [16:0] baddr;
		logic [8:0]  entry;
		logic [7:0]  b0;
		logic [7:0]  b1;
		maddr = insn[31:15];
		caddr = insn[14:6];
		op    = insn[5:0];
		case (op)
			op_set_vbp:     ref_vbp = maddr;
			op_add_vbp:     ref_vbp = ref_vbp + maddr;
			op_set_sbp:     ref_sbp = maddr;
			op_add_sbp:     ref_sbp = ref_sbp + maddr;
			op_set_cbp:     ref_cbp = caddr;
			op_add_cbp:     ref_cbp = ref_cbp + caddr;
			op_load_coeff0: ref_coeff[caddr][63:0] = exp_mem[maddr[16:1]];
			op_load_coeff1: ref_coeff[caddr][127:64] = exp_mem[maddr[16:1]];
			op_macc, op_maccz: begin
				baddr = maddr + ref_vbp;
				entry = caddr + ref_cbp;
				if (op == op_maccz) begin
					ref_acc0 = 0;
					ref_acc1 = 0;
				end
				ref_acc0 += dot8(exp_mem[baddr[16:1]], ref_coeff[entry][63:0]);
				ref_acc1 += dot8(exp_mem[baddr[16:1]], ref_coeff[entry][127:64]);
			end
			op_store, op_store0, op_store1, op_relu, op_relu0, op_relu1: begin
				b0    = to_byte(ref_acc0, caddr);
				b1    = to_byte(ref_acc1, caddr);
				baddr = maddr + ref_sbp;
				if (op == op_relu || op == op_relu0 || op == op_relu1) begin
					b0 = b0[7] ? 8'h00 : b0;
					b1 = b1[7] ? 8'h00 : b1;
				end
				if (op != op_store1 && op != op_relu1) begin
					exp_mem[baddr[16:1]][8*baddr[0] +: 8] = b0;
				end
				if (op != op_store0 && op != op_relu0) begin
					exp_mem[baddr[16:1]][8*baddr[0] + 8 +: 8] = b1;
				end
				touched.push_back(baddr[16:1]);
			end
			default: ;
		endcase
	endfunction

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------

	task automatic check_byte(string name, logic [7:0] got, logic [7:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_flag(string name, logic got, logic expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("Mismatch at time %0t: %s got %b expected %b", $time, name, got, expected);
		end
	endtask

`endif

// ==== tests/marlann_tb.sv ====
`timescale 1ns/1ps

module marlann_tb;
	import marlann_pkg::*;

	localparam int num_programs = 40;
	localparam int program_len  = 7;  // Two loads, up to four MACCs and one store.
	localparam int directed_len = 28;
	localparam int cycle_limit  = (directed_len + num_programs * program_len) * (pipe_depth + 4)
	                              + 200;
	localparam logic [opcode_width-1:0] store_ops [6] = '{
		op_store, op_store0, op_store1, op_relu, op_relu0, op_relu1
	};

	logic                      clock;
	logic                      reset;
	logic                      busy;
	logic                      cmd_valid;
	logic                      cmd_ready;
	logic [31:0]               cmd_insn;
	logic                      mem_ren;
	logic [mem_lanes-1:0]      mem_wen;
	logic [mem_addr_width-1:0] mem_addr;
	logic [mem_data_width-1:0] mem_wdata;
	logic [mem_data_width-1:0] mem_rdata = '0;
	logic [mem_data_width-1:0] read_q = '0;  // First stage of the read pipeline.
	logic [mem_data_width-1:0] mem [0:65535];
	logic                      compare_req;
	int                        cycles = 0;

	`include "marlann_tb_ref.svh"

	marlann_top #(
		.coeff_depth (512)
	) dut (
		.clock     (clock),
		.reset     (reset),
		.busy      (busy),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_insn  (cmd_insn),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	always #5 clock = ~clock;

	// ------------------------------------------------------------
	// Memory model with byte enables and a two cycle read latency
	// ------------------------------------------------------------

	always @(posedge clock) begin : memory_model
		logic [mem_data_width-1:0] merged;
		merged = mem[mem_addr];
		for (int l = 0; l < mem_lanes; l++) begin
			if (mem_wen[l]) begin
				merged[8*l +: 8] = mem_wdata[8*l +: 8];
			end
		end
		if (mem_wen != 0) begin
			mem[mem_addr] <= merged;
		end
		if (mem_ren) begin
			read_q <= mem[mem_addr];
		end
		mem_rdata <= read_q;
	end

	// Reads and writes must never share the memory port.
	always @(negedge clock) begin
		if (!reset) begin
			check_flag("mem_ren with mem_wen", mem_ren && (mem_wen != 0), 1'b0);
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Compares every word a store touched against the model.
	always begin
		wait (compare_req);
		foreach (touched[i]) begin
			for (int l = 0; l < mem_lanes; l++) begin
				check_byte($sformatf("mem[%0d] lane %0d", touched[i], l),
				           mem[touched[i]][8*l +: 8], exp_mem[touched[i]][8*l +: 8]);
			end
		end
		touched.delete();
		compare_req = 1'b0;
	end

	function automatic logic [63:0] fill_word(logic [15:0] a);
		return {a ^ 16'h3c5a, ~a, a[7:0], a[15:8], a * 16'd40503};
	endfunction

	task automatic poke_word(logic [15:0] word, logic [63:0] data);
		mem[word] <= data;
		exp_mem[word] = data;
	endtask

	// Holds the command until the DUT takes it.
	task automatic send_command(logic [5:0] op, logic [16:0] maddr, logic [8:0] caddr);
		logic ready_seen;
		cmd_valid = 1'b1;
		cmd_insn  = {maddr, caddr, op};
		do begin
			@(negedge clock);
			ready_seen = cmd_ready;
			@(posedge clock);
			#1;
		end while (!ready_seen);
		cmd_valid = 1'b0;
		apply_command({maddr, caddr, op});
	endtask

	task automatic drain_and_compare();
		do begin
			@(posedge clock);
			#1;
		end while (busy);
		compare_req = 1'b1;
		wait (!compare_req);
	endtask

	task automatic report_test(string name, int errors_before);
		$display("test %s: %0d errors", name, error_count - errors_before);
	endtask

	initial begin
		int         start_errors;
		int         n_macc;
		logic [8:0] entry;
		clock       = 1'b0;
		reset       = 1'b1;
		cmd_valid   = 1'b0;
		cmd_insn    = '0;
		compare_req = 1'b0;
		lcg_state   = 32'h1b1c;
		ref_vbp     = '0;
		ref_sbp     = '0;
		ref_cbp     = '0;
		ref_acc0    = 0;
		ref_acc1    = 0;
		check_count = 0;
		error_count = 0;
		for (int a = 0; a < 65536; a++) begin
			mem[a] <= fill_word(16'(a));
			exp_mem[a] = fill_word(16'(a));
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		start_errors = error_count;
		@(posedge clock);
		#1;
		check_flag("busy", busy, 1'b0);
		check_flag("cmd_ready", cmd_ready, 1'b1);
		check_flag("mem_ren", mem_ren, 1'b0);
		check_flag("mem_wen any", |mem_wen, 1'b0);
		report_test("reset state", start_errors);

		// Small operands, so both dot products fit a byte at shift 0.
		start_errors = error_count;
		poke_word(16'd16, 64'hfe02_0100_03ff_0201);
		poke_word(16'd20, 64'h0101_0101_0101_0101);
		poke_word(16'd21, 64'h0100_0103_ff01_0002);
		send_command(op_load_coeff0, 17'd40, 9'd3);
		send_command(op_load_coeff1, 17'd42, 9'd3);
		send_command(op_maccz, 17'd32, 9'd3);
		send_command(op_store, 17'd200, 9'd0);
		drain_and_compare();
		report_test("dot product", start_errors);

		start_errors = error_count;
		poke_word(16'd22, {8{8'h7f}});
		poke_word(16'd23, {8{8'h80}});
		poke_word(16'd24, {8{8'h7f}});
		send_command(op_load_coeff0, 17'd44, 9'd4);
		send_command(op_load_coeff1, 17'd46, 9'd4);
		send_command(op_maccz, 17'd48, 9'd4);
		send_command(op_macc, 17'd48, 9'd4);
		send_command(op_macc, 17'd48, 9'd4);
		send_command(op_store, 17'd301, 9'd2);
		send_command(op_relu, 17'd310, 9'd2);
		send_command(op_store0, 17'd320, 9'd0);
		send_command(op_store1, 17'd331, 9'd0);
		send_command(op_relu1, 17'd351, 9'd20);
		drain_and_compare();
		report_test("accumulate and saturate", start_errors);

		start_errors = error_count;
		send_command(op_set_vbp, 17'd8, 9'd0);
		send_command(op_add_vbp, 17'd2, 9'd0);
		send_command(op_set_cbp, 17'd0, 9'd3);
		send_command(op_add_cbp, 17'd0, 9'd1);
		send_command(op_set_sbp, 17'd400, 9'd0);
		send_command(op_add_sbp, 17'd3, 9'd0);
		send_command(op_maccz, 17'd38, 9'd0);
		send_command(op_store, 17'd0, 9'd12);
		send_command(op_set_vbp, 17'd0, 9'd0);
		send_command(op_set_cbp, 17'd0, 9'd0);
		send_command(op_set_sbp, 17'd0, 9'd0);
		drain_and_compare();
		report_test("base pointers", start_errors);

		// The MACC reads the word the store before it writes.
		start_errors = error_count;
		send_command(op_store, 17'd48, 9'd0);
		send_command(op_macc, 17'd48, 9'd4);
		send_command(op_store, 17'd500, 9'd12);
		drain_and_compare();
		report_test("interlock", start_errors);

		start_errors = error_count;
		for (int p = 0; p < num_programs; p++) begin
			entry = 9'(rand_below(8));
			for (int w = 0; w < 4; w++) begin
				poke_word(16'(1024 + w), {lcg_next(), lcg_next()});
			end
			poke_word(16'd1040, {lcg_next(), lcg_next()});
			poke_word(16'd1041, {lcg_next(), lcg_next()});
			send_command(op_load_coeff0, 17'd2080, entry);
			send_command(op_load_coeff1, 17'd2082, entry);
			n_macc = 1 + rand_below(4);
			for (int m = 0; m < n_macc; m++) begin
				send_command(rand_below(2) ? op_macc : op_maccz,
				             17'(2048 + 2 * rand_below(4)), entry);
			end
			send_command(store_ops[rand_below(6)], 17'(3000 + rand_below(64)),
			             9'(rand_below(24)));
			drain_and_compare();
		end
		report_test("random programs", start_errors);

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/marlann_top.sv ====
`timescale 1ns/1ps

module marlann_top #(
	parameter int coeff_depth = 512
) (
	input  logic                                    clock,
	input  logic                                    reset,
	output logic                                    busy,
	input  logic                                    cmd_valid,
	output logic                                    cmd_ready,
	input  logic [31:0]                             cmd_insn,
	output logic                                    mem_ren,
	output logic [marlann_pkg::mem_lanes-1:0]       mem_wen,
	output logic [marlann_pkg::mem_addr_width-1:0]  mem_addr,
	output logic [marlann_pkg::mem_data_width-1:0]  mem_wdata,
	input  logic [marlann_pkg::mem_data_width-1:0]  mem_rdata
);
	import marlann_pkg::*;

	marlann_pipe_if p_issue ();
	marlann_pipe_if p_coeff ();
	marlann_pipe_if p_mac ();
	marlann_pipe_if p_accum ();

	logic [mem_addr_width-1:0]   rd_addr;
	logic [mem_addr_width-1:0]   wr_addr;
	logic [2*mem_data_width-1:0] coeff;
	logic [mem_data_width-1:0]   rdata;
	logic [sum_width-1:0]        sum0;
	logic [sum_width-1:0]        sum1;
	logic [7:0]                  sat0;
	logic [7:0]                  sat1;

	assign mem_addr = mem_ren ? rd_addr : wr_addr; // The interlock keeps the two apart.

	marlann_issue issue (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_insn  (cmd_insn),
		.cmd_ready (cmd_ready),
		.busy      (busy),
		.mem_ren   (mem_ren),
		.rd_addr   (rd_addr),
		.next_item (p_issue)
	);

	marlann_coeff #(
		.coeff_depth (coeff_depth)
	) coeff_stage (
		.clock     (clock),
		.reset     (reset),
		.mem_rdata (mem_rdata),
		.prev_item (p_issue),
		.coeff     (coeff),
		.rdata     (rdata),
		.next_item (p_coeff)
	);

	marlann_mac mac (
		.clock     (clock),
		.reset     (reset),
		.coeff     (coeff),
		.rdata     (rdata),
		.prev_item (p_coeff),
		.sum0      (sum0),
		.sum1      (sum1),
		.next_item (p_mac)
	);

	marlann_accum accum (
		.clock     (clock),
		.reset     (reset),
		.sum0      (sum0),
		.sum1      (sum1),
		.prev_item (p_mac),
		.sat0      (sat0),
		.sat1      (sat1),
		.next_item (p_accum)
	);

	marlann_writeback writeback (
		.clock     (clock),
		.reset     (reset),
		.sat0      (sat0),
		.sat1      (sat1),
		.prev_item (p_accum),
		.mem_wen   (mem_wen),
		.wr_addr   (wr_addr),
		.mem_wdata (mem_wdata)
	);

endmodule
